//--- hw/vis_buffer_defs.svh
`ifndef VIS_BUFFER_DEFS_SVH
`define VIS_BUFFER_DEFS_SVH

// --------------------------------------------------
// capture buffer sizing
// --------------------------------------------------

// words per frame, legal range 1 to 128
`define VB_FRAME_WORDS 16

// ram address = {bank, word index}
`define VB_ADDR_W 8

// two banks, ping-pong
`define VB_BANKS 2

// saturating drop counter
`define VB_DROP_W 16

`endif

//--- hw/vis_buffer_pkg.sv
package vis_buffer_pkg;

   // --------------------------------------------------
   // vectors with a meaning
   // --------------------------------------------------
   typedef logic [63:0] vis_word_t;   // one correlator visibility
   typedef logic [7:0]  ram_addr_t;   // {bank, index} into both rams
   typedef logic [6:0]  frame_idx_t;  // word slot inside one bank

   // --------------------------------------------------
   // bundles
   // --------------------------------------------------
   typedef struct packed {
      logic      we;                  // write strobe, both halves
      ram_addr_t addr;
      vis_word_t data;                // split lo/hi at the top
   } ram_wr_t;

   typedef struct packed {
      vis_word_t data;
      logic      last;                // final word of a frame
   } vis_out_t;

   typedef enum logic [2:0] {
      idle,                           // wait for a full bank
      fetch,                          // rd_en high
      load,                           // ram output valid, latch it
      req_high,                       // out_req up, wait ack
      req_low                         // out_req down, wait ack low
   } rd_state_e;

endpackage

//--- hw/sdp_ram_256x32.sv
module sdp_ram_256x32 (
   input  logic        WCLK,
   input  logic        we,            // write port
   input  logic [7:0]  waddr,
   input  logic [31:0] di,
   input  logic        ce,            // read port
   input  logic [7:0]  raddr,
   output logic [31:0] dout
);

   // --------------------------------------------------
   // storage array
   // --------------------------------------------------
   logic [31:0] mem [0:255];
   logic [31:0] dout_q;               // read output register

   assign dout = dout_q;

   // synchronous write
   always_ff @(posedge WCLK) begin
      if (we) begin
         mem[waddr] <= di;
      end
   end

   // read register holds while ce low
   always_ff @(posedge WCLK) begin
      if (ce) begin
         dout_q <= mem[raddr];        // old data on same-address write
      end
   end

endmodule

//--- hw/capture_writer.sv
`include "vis_buffer_defs.svh"

module capture_writer
   import vis_buffer_pkg::*;
(
   input  logic                   WCLK,
   input  logic                   rst,
   input  logic                   sample_valid,  // no back-pressure
   input  vis_word_t              sample_data,
   output ram_wr_t                ram_wr,        // to both ram halves
   output logic [`VB_BANKS-1:0]   bank_full,     // owned here
   input  logic                   bank_release,  // pulse from reader
   input  logic                   release_bank,  // which bank to free
   output logic [`VB_DROP_W-1:0]  drop_count
);

   // --------------------------------------------------
   // write pointer
   // --------------------------------------------------
   logic                 wr_bank;                // bank being filled
   frame_idx_t           wr_idx;                 // next slot in that bank
   logic [`VB_ADDR_W-1:0] wr_addr;
   logic                 accept;                 // sample goes to ram
   logic                 drop;                   // sample lost, bank busy
   logic                 frame_end;              // last slot of the frame

   assign wr_addr   = {wr_bank, wr_idx};
   assign accept    = sample_valid & ~bank_full[wr_bank];
   assign drop      = sample_valid & bank_full[wr_bank];
   assign frame_end = (wr_idx == frame_idx_t'(`VB_FRAME_WORDS - 1));

   // write lands on the same edge that samples it
   assign ram_wr.we   = accept;
   assign ram_wr.addr = ram_addr_t'(wr_addr);
   assign ram_wr.data = sample_data;

   // --------------------------------------------------
   // bank flags and pointer update
   // --------------------------------------------------
   always_ff @(posedge WCLK) begin
      if (rst) begin
         wr_bank   <= 1'b0;
         wr_idx    <= '0;
         bank_full <= '0;
      end else begin
         if (bank_release) begin
            bank_full[release_bank] <= 1'b0;     // reader done with it
         end
         if (accept) begin
            if (frame_end) begin
               bank_full[wr_bank] <= 1'b1;       // whole frame stored
               wr_bank            <= ~wr_bank;   // ping-pong
               wr_idx             <= '0;
            end else begin
               wr_idx <= wr_idx + 1'b1;
            end
         end
      end
   end

   // --------------------------------------------------
   // drop counter
   // --------------------------------------------------
   // a full target bank drops the sample, the pointer does not move,
   // so a bank only ever holds complete frames
   always_ff @(posedge WCLK) begin
      if (rst) begin
         drop_count <= '0;
      end else if (drop && (drop_count != {`VB_DROP_W{1'b1}})) begin
         drop_count <= drop_count + 1'b1;        // saturates at all ones
      end
   end

endmodule

//--- hw/frame_reader.sv
`include "vis_buffer_defs.svh"

module frame_reader
   import vis_buffer_pkg::*;
(
   input  logic                  WCLK,
   input  logic                  rst,
   input  logic [`VB_BANKS-1:0]  bank_full,     // from writer
   output logic                  rd_en,         // ce of both rams
   output ram_addr_t             rd_addr,
   input  vis_word_t             rd_data,       // one cycle after rd_en
   output logic                  bank_release,  // one-cycle pulse
   output logic                  release_bank,
   output logic                  out_req,       // four-phase output
   input  logic                  out_ack,
   output vis_out_t              out_word
);

   // --------------------------------------------------
   // read pointer and state
   // --------------------------------------------------
   rd_state_e             state;
   logic                  rd_bank;              // bank being drained
   frame_idx_t            rd_idx;               // word within that bank
   logic [`VB_ADDR_W-1:0] rd_addr_c;
   logic                  idx_last;             // fetching final word

   assign rd_addr_c = {rd_bank, rd_idx};
   assign rd_addr   = ram_addr_t'(rd_addr_c);
   assign idx_last  = (rd_idx == frame_idx_t'(`VB_FRAME_WORDS - 1));

   assign rd_en   = (state == fetch);           // one read per word
   assign out_req = (state == req_high);

   // --------------------------------------------------
   // FSM
   // --------------------------------------------------
   always_ff @(posedge WCLK) begin
      if (rst) begin
         state        <= idle;
         rd_bank      <= 1'b0;
         rd_idx       <= '0;
         bank_release <= 1'b0;
         release_bank <= 1'b0;
      end else begin
         bank_release <= 1'b0;                  // default, pulse only
         case (state)
            idle: begin
               if (bank_full[rd_bank]) begin
                  state <= fetch;               // frame ready
               end
            end
            fetch: begin
               state <= load;                   // ram registers the word
            end
            load: begin
               state <= req_high;               // hold reg filled here
            end
            req_high: begin
               if (out_ack) begin
                  state <= req_low;             // consumer took it
               end
            end
            req_low: begin
               if (!out_ack) begin              // handshake closed
                  if (out_word.last) begin
                     bank_release <= 1'b1;
                     release_bank <= rd_bank;
                     rd_bank      <= ~rd_bank;  // other bank next
                     rd_idx       <= '0;
                     state        <= idle;
                  end else begin
                     rd_idx <= rd_idx + 1'b1;
                     state  <= fetch;
                  end
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // --------------------------------------------------
   // output hold register
   // --------------------------------------------------
   // loaded only in load, where req and ack are both low
   always_ff @(posedge WCLK) begin
      if (state == load) begin
         out_word.data <= rd_data;
         out_word.last <= idx_last;             // frame boundary tag
      end
   end

endmodule

//--- hw/vis_buffer_top.sv
`include "vis_buffer_defs.svh"

module vis_buffer_top
   import vis_buffer_pkg::*;
(
   input  logic                  WCLK,
   input  logic                  rst,
   input  logic                  sample_valid,  // correlator strobe
   input  vis_word_t             sample_data,
   output logic                  out_req,       // four-phase output
   input  logic                  out_ack,
   output vis_out_t              out_word,
   output logic [`VB_DROP_W-1:0] drop_count     // lost samples
);

   // --------------------------------------------------
   // internal nets
   // --------------------------------------------------
   ram_wr_t              ram_wr;        // writer command
   logic [`VB_BANKS-1:0] bank_full;
   logic                 bank_release;
   logic                 release_bank;
   logic                 rd_en;
   ram_addr_t            rd_addr;
   logic [31:0]          rd_data_lo;
   logic [31:0]          rd_data_hi;
   vis_word_t            rd_data;

   assign rd_data = {rd_data_hi, rd_data_lo};  // rejoin the halves

   // --------------------------------------------------
   // control
   // --------------------------------------------------
   capture_writer capture_writer_inst (
      .WCLK         (WCLK),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .ram_wr       (ram_wr),
      .bank_full    (bank_full),
      .bank_release (bank_release),
      .release_bank (release_bank),
      .drop_count   (drop_count)
   );

   frame_reader frame_reader_inst (
      .WCLK         (WCLK),
      .rst          (rst),
      .bank_full    (bank_full),
      .rd_en        (rd_en),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data),
      .bank_release (bank_release),
      .release_bank (release_bank),
      .out_req      (out_req),
      .out_ack      (out_ack),
      .out_word     (out_word)
   );

   // --------------------------------------------------
   // 64-bit store from two 32-bit rams
   // --------------------------------------------------
   sdp_ram_256x32 ram_lo (
      .WCLK  (WCLK),
      .we    (ram_wr.we),
      .waddr (ram_wr.addr),
      .di    (ram_wr.data[31:0]),     // low half
      .ce    (rd_en),
      .raddr (rd_addr),
      .dout  (rd_data_lo)
   );

   sdp_ram_256x32 ram_hi (
      .WCLK  (WCLK),
      .we    (ram_wr.we),
      .waddr (ram_wr.addr),
      .di    (ram_wr.data[63:32]),    // high half
      .ce    (rd_en),
      .raddr (rd_addr),
      .dout  (rd_data_hi)
   );

endmodule

//--- verification/vis_buffer_tb.sv
`include "vis_buffer_defs.svh"

module vis_buffer_tb
   import vis_buffer_pkg::*;
();

   // --------------------------------------------------
   // run length and timing
   // --------------------------------------------------
   localparam int CLK_PERIOD      = 8;
   localparam int FW              = `VB_FRAME_WORDS;
   localparam int LIGHT_CYCLES    = 1000;             // sparse input
   localparam int STRESS_CYCLES   = 800;              // dense input, random ack
   localparam int OVF_CYCLES      = 4 * FW;           // ack held off
   localparam int TOTAL_CYCLES    = LIGHT_CYCLES + STRESS_CYCLES + OVF_CYCLES;
   localparam int WATCHDOG_CYCLES = TOTAL_CYCLES * 16 + 4000;
   localparam int QUIET_CYCLES    = 32;               // idle output = drained
   localparam int ACK_TABLE       = 64;

   logic                  WCLK = 1'b0;
   logic                  rst;
   logic                  sample_valid;
   vis_word_t             sample_data;
   logic                  out_req;
   logic                  out_ack;
   vis_out_t              out_word;
   logic [`VB_DROP_W-1:0] drop_count;

   int        seed = 65862;
   vis_word_t sent_q [$];                             // every sample driven
   int        ack_delay [0:ACK_TABLE-1];              // 0..5 cycles
   string     test_name;
   logic      fast_ack;                               // answer at once
   logic      ack_hold;                               // stall the consumer

   int        recv_count;                             // consumer side
   int        model_ptr;                              // next candidate in sent_q
   int        skipped;                                // sent words never seen
   int        word_errors;
   int        protocol_errors;
   int        check_errors;
   int        drops_before;
   int        leftover;

   always #(CLK_PERIOD / 2) WCLK = ~WCLK;

   vis_buffer_top vis_buffer_top_inst (
      .WCLK         (WCLK),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .out_req      (out_req),
      .out_ack      (out_ack),
      .out_word     (out_word),
      .drop_count   (drop_count)
   );

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % n;
   endfunction

   // one sample per cycle at the given percent density
   task automatic send_samples(input int cycles, input int density);
      int        i;
      vis_word_t word;
      for (i = 0; i < cycles; i++) begin
         @(posedge WCLK);
         if (rand_below(100) < density) begin
            word = {$random(seed), $random(seed)};
            sample_valid <= 1'b1;
            sample_data  <= word;
            sent_q.push_back(word);
         end else begin
            sample_valid <= 1'b0;
         end
      end
      @(posedge WCLK);
      sample_valid <= 1'b0;
   endtask

   // output counts as drained once req and ack stay low for a while
   task automatic drain_output();
      int quiet;
      quiet = 0;
      while (quiet < QUIET_CYCLES) begin
         @(posedge WCLK);
         if (out_req || out_ack) begin
            quiet = 0;
         end else begin
            quiet++;
         end
      end
   endtask

   // --------------------------------------------------
   // order model
   // --------------------------------------------------
   task automatic check_word(input vis_out_t got);
      int   slot;
      int   k;
      logic found;
      logic exp_last;
      slot     = recv_count % FW;
      exp_last = (slot == FW - 1);                     // every FW-th word
      if (got.last !== exp_last) begin
         $display("MISMATCH %s last of word %0d: expected %b, actual %b",
                  test_name, recv_count, exp_last, got.last);
         word_errors++;
      end
      if (slot == 0) begin                             // dropped samples only before a frame
         k     = model_ptr;
         found = 1'b0;
         while (k < sent_q.size() && !found) begin
            if (sent_q[k] == got.data) begin
               found = 1'b1;
            end else begin
               k++;
            end
         end
         if (found) begin
            skipped  += k - model_ptr;
            model_ptr = k;
         end
      end
      if (model_ptr >= sent_q.size()) begin
         $display("%s: word %h came out with no sent sample left to match it",
                  test_name, got.data);
         word_errors++;
      end else begin
         if (got.data !== sent_q[model_ptr]) begin
            $display("MISMATCH %s word %0d: expected %h, actual %h",
                     test_name, recv_count, sent_q[model_ptr], got.data);
            word_errors++;
         end
         model_ptr++;                                  // no gap inside a frame
      end
      recv_count++;
   endtask

   // --------------------------------------------------
   // four-phase consumer
   // --------------------------------------------------
   initial begin : consumer
      int delay;
      out_ack     = 1'b0;
      recv_count  = 0;
      model_ptr   = 0;
      skipped     = 0;
      word_errors = 0;
      forever begin
         @(posedge WCLK);
         if (out_req && !out_ack) begin
            while (ack_hold) begin
               @(posedge WCLK);
            end
            delay = fast_ack ? 0 : ack_delay[recv_count % ACK_TABLE];
            repeat (delay) @(posedge WCLK);
            check_word(out_word);                      // stable while req high
            out_ack <= 1'b1;
            do begin
               @(posedge WCLK);
            end while (out_req);
            out_ack <= 1'b0;                           // close the exchange
         end
      end
   end

   // --------------------------------------------------
   // handshake monitor
   // --------------------------------------------------
   logic     prev_req;
   logic     prev_ack;
   vis_out_t prev_word;

   initial protocol_errors = 0;

   always @(posedge WCLK) begin
      if (rst) begin
         prev_req <= 1'b0;
         prev_ack <= 1'b0;
      end else begin
         if ((prev_req || prev_ack) && (out_word !== prev_word)) begin
            $display("%s: out_word changed while out_req or out_ack was high", test_name);
            protocol_errors++;
         end
         if (!prev_req && out_req && prev_ack) begin
            $display("%s: out_req rose while out_ack was still high", test_name);
            protocol_errors++;
         end
         prev_req  <= out_req;
         prev_ack  <= out_ack;
         prev_word <= out_word;
      end
   end

   // --------------------------------------------------
   // watchdog
   // --------------------------------------------------
   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Testbench failed");
      $finish;
   end

   // --------------------------------------------------
   // phases
   // --------------------------------------------------
   initial begin : stimulus
      int i;
      rst          = 1'b1;
      sample_valid = 1'b0;
      sample_data  = '0;
      fast_ack     = 1'b0;
      ack_hold     = 1'b0;
      check_errors = 0;
      test_name    = "reset";
      for (i = 0; i < ACK_TABLE; i++) begin
         ack_delay[i] = rand_below(6);
      end
      repeat (4) @(posedge WCLK);
      rst <= 1'b0;
      @(posedge WCLK);

      test_name = "light_load";                        // no drops expected
      fast_ack  = 1'b1;
      send_samples(LIGHT_CYCLES, 5);
      drain_output();
      if (drop_count != '0) begin
         $display("MISMATCH %s drop_count: expected 0, actual %0d",
                  test_name, drop_count);
         check_errors++;
      end

      test_name = "random_stress";                     // drops allowed
      fast_ack  = 1'b0;
      send_samples(STRESS_CYCLES, 50);
      drain_output();

      test_name    = "overflow";
      drops_before = int'(drop_count);
      ack_hold     = 1'b1;                             // both banks fill up
      send_samples(OVF_CYCLES, 100);
      if (int'(drop_count) <= drops_before) begin
         $display("%s: drop_count did not grow while ack was held off", test_name);
         check_errors++;
      end
      ack_hold = 1'b0;
      drain_output();

      test_name = "final";
      leftover  = sent_q.size() - recv_count - int'(drop_count);
      if (recv_count == 0) begin
         $display("%s: no word came out of the buffer", test_name);
         check_errors++;
      end
      if (recv_count % FW != 0) begin
         $display("%s: %0d words received, not a whole number of frames",
                  test_name, recv_count);
         check_errors++;
      end
      if (leftover < 0 || leftover >= FW) begin
         $display("%s: %0d sent, %0d received, %0d dropped do not add up",
                  test_name, sent_q.size(), recv_count, drop_count);
         check_errors++;
      end
      if (skipped > int'(drop_count)) begin
         $display("%s: %0d samples missing from the output but only %0d dropped",
                  test_name, skipped, drop_count);
         check_errors++;
      end

      $display("errors: %0d word, %0d protocol, %0d phase (%0d sent, %0d received, %0d dropped)",
               word_errors, protocol_errors, check_errors,
               sent_q.size(), recv_count, drop_count);
      if (word_errors + protocol_errors + check_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+hw
hw/vis_buffer_pkg.sv
hw/sdp_ram_256x32.sv
hw/capture_writer.sv
hw/frame_reader.sv
hw/vis_buffer_top.sv
verification/vis_buffer_tb.sv

//--- Makefile
# Verilator build and run of the visibility capture buffer testbench

VERILATOR ?= verilator
TOP       ?= vis_buffer_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Testbench passed

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, look for the pass line"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
